// File: design/channel_error.sv
`timescale 1ns/10ps

module channel_error (
    input  logic                clk_i,
    input  logic                arst_n_i,
    dsp_cfg_if.chan             cfg,
    input  dsp_pkg::bit_word_t  bits_cur_i,
    input  dsp_pkg::bit_word_t  bits_prev_i,
    input  dsp_pkg::code_word_t codes_i,
    output dsp_pkg::est_word_t  errors_o
);
    import dsp_pkg::*;

    logic [2*lanes-1:0] bstream;
    est_word_t          errors_d;

    // Bit at stream index n sits at lanes + n
    assign bstream = {bits_cur_i, bits_prev_i};

    always_comb begin
        logic signed [chan_acc_w-1:0] acc;
        logic signed [chan_acc_w-1:0] tap;
        logic signed [err_diff_w-1:0] diff;
        est_t                         est;
        for (int n = 0; n < lanes; n++) begin
            acc = '0;
            for (int k = 0; k < chan_taps; k++) begin
                tap = $signed(cfg.chan_taps_val[k]);
                // Bit 1 is symbol +1, bit 0 is symbol -1
                if (bstream[lanes + n - k]) begin
                    acc = acc + tap;
                end else begin
                    acc = acc - tap;
                end
            end
            est = sat_est(acc >>> cfg.chan_shift);
            diff = est - $signed(codes_i[n]);
            errors_d[n] = sat_est(diff);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            errors_o <= '0;
        end else begin
            errors_o <= errors_d;
        end
    end

endmodule

// File: design/datapath_core.sv
`timescale 1ns/10ps

module datapath_core (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  dsp_pkg::code_word_t    adc_codes_i,
    input  dsp_pkg::ffe_coef_t     ffe_weights_i,
    input  dsp_pkg::shift_t        ffe_shift_i,
    input  dsp_pkg::est_t          slice_thresh_i,
    input  dsp_pkg::chan_coef_t    chan_taps_i,
    input  dsp_pkg::shift_t        chan_shift_i,
    output dsp_pkg::bit_word_t     bits_o,
    output dsp_pkg::est_word_t     errors_o,
    output dsp_pkg::err_pos_word_t err_pos_o
);
    import dsp_pkg::*;

    code_word_t code_taps [delay_depth];
    bit_word_t  bit_taps  [delay_depth];

    dsp_cfg_if cfg_bus ();

    assign cfg_bus.ffe_weights   = ffe_weights_i;
    assign cfg_bus.ffe_shift     = ffe_shift_i;
    assign cfg_bus.slice_thresh  = slice_thresh_i;
    assign cfg_bus.chan_taps_val = chan_taps_i;
    assign cfg_bus.chan_shift    = chan_shift_i;

    // ADC words, tap 1 lines up with the sliced bits
    word_delay #(
        .word_t (code_word_t),
        .depth  (delay_depth)
    ) code_delay (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .word_i   (adc_codes_i),
        .taps_o   (code_taps)
    );

    ffe_slicer u_ffe_slicer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cfg          (cfg_bus.ffe),
        .codes_cur_i  (code_taps[0]),
        .codes_prev_i (code_taps[1]),
        .bits_o       (bits_o)
    );

    word_delay #(
        .word_t (bit_word_t),
        .depth  (delay_depth)
    ) bit_delay (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .word_i   (bits_o),
        .taps_o   (bit_taps)
    );

    channel_error u_channel_error (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg         (cfg_bus.chan),
        .bits_cur_i  (bits_o),
        .bits_prev_i (bit_taps[0]),
        .codes_i     (code_taps[1]),
        .errors_o    (errors_o)
    );

    // Bits one word behind the error path
    sliding_detector u_sliding_detector (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg         (cfg_bus.det),
        .errors_i    (errors_o),
        .bits_cur_i  (bit_taps[0]),
        .bits_prev_i (bit_taps[1]),
        .err_pos_o   (err_pos_o)
    );

endmodule

// File: design/dsp_cfg_if.sv
`timescale 1ns/10ps

interface dsp_cfg_if;
    import dsp_pkg::*;

    // Equalizer and slicer settings
    ffe_coef_t  ffe_weights;
    shift_t     ffe_shift;
    est_t       slice_thresh;

    // Channel model, shared by error path and detector
    chan_coef_t chan_taps_val;
    shift_t     chan_shift;

    modport ffe (
        input ffe_weights,
        input ffe_shift,
        input slice_thresh
    );

    modport chan (
        input chan_taps_val,
        input chan_shift
    );

    modport det (
        input chan_taps_val,
        input chan_shift
    );

endinterface

// File: design/dsp_pkg.sv
package dsp_pkg;

    localparam int lanes     = 4;
    localparam int code_w    = 8;
    localparam int ffe_taps  = 3;
    localparam int chan_taps = 3;
    localparam int coef_w    = 8;
    localparam int shift_w   = 4;
    localparam int est_w     = 10;

    // Current plus previous word
    localparam int delay_depth   = 2;
    localparam int ffe_shift_max = 11;

    // Internal arithmetic widths
    localparam int ffe_acc_w  = coef_w + code_w + $clog2(ffe_taps);
    localparam int chan_acc_w = coef_w + 1 + $clog2(chan_taps);
    localparam int err_diff_w = est_w + 1;
    localparam int det_diff_w = est_w + 1;
    localparam int cost_w     = 2 * det_diff_w;
    localparam int sat_in_w   = ffe_acc_w;

    localparam int est_max = 2 ** (est_w - 1) - 1;
    localparam int est_min = -(2 ** (est_w - 1));

    typedef logic signed [code_w-1:0] code_t;
    typedef code_t [lanes-1:0] code_word_t;

    typedef logic [lanes-1:0] bit_word_t;

    typedef logic signed [est_w-1:0] est_t;
    typedef est_t [lanes-1:0] est_word_t;

    typedef logic signed [coef_w-1:0] coef_t;
    typedef coef_t [ffe_taps-1:0] ffe_coef_t;
    typedef coef_t [chan_taps-1:0] chan_coef_t;

    typedef logic [shift_w-1:0] shift_t;

    // Detector result encoding, 3 unused
    typedef logic [1:0] err_pos_t;
    typedef err_pos_t [lanes-1:0] err_pos_word_t;

    localparam err_pos_t pos_none = 2'd0;
    localparam err_pos_t pos_cur  = 2'd1;
    localparam err_pos_t pos_prev = 2'd2;

    // Clamp a wide signed value into the est_w range
    function automatic est_t sat_est(input logic signed [sat_in_w-1:0] x);
        if (x > est_max) begin
            return est_t'(est_max);
        end else if (x < est_min) begin
            return est_t'(est_min);
        end
        return est_t'(x);
    endfunction

endpackage

// File: design/ffe_slicer.sv
`timescale 1ns/10ps

module ffe_slicer (
    input  logic                clk_i,
    input  logic                arst_n_i,
    dsp_cfg_if.ffe              cfg,
    input  dsp_pkg::code_word_t codes_cur_i,
    input  dsp_pkg::code_word_t codes_prev_i,
    output dsp_pkg::bit_word_t  bits_o
);
    import dsp_pkg::*;

    // Previous word in the low half, current in the high half
    code_t     stream [2*lanes];
    bit_word_t bits_d;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            stream[i]         = codes_prev_i[i];
            stream[lanes + i] = codes_cur_i[i];
        end
    end

    // FIR over the serial stream, then shift, clamp and slice
    always_comb begin
        logic signed [ffe_acc_w-1:0] acc;
        est_t                        eq;
        for (int n = 0; n < lanes; n++) begin
            acc = '0;
            for (int k = 0; k < ffe_taps; k++) begin
                acc = acc + $signed(cfg.ffe_weights[k]) * stream[lanes + n - k];
            end
            eq = sat_est(acc >>> cfg.ffe_shift);
            bits_d[n] = (eq >= cfg.slice_thresh);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= bits_d;
        end
    end

    // Larger shifts leave too few product bits
    a_ffe_shift: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cfg.ffe_shift <= ffe_shift_max
    ) else $error("FFE shift %0d out of range", cfg.ffe_shift);

endmodule

// File: design/sliding_detector.sv
`timescale 1ns/10ps

module sliding_detector (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    dsp_cfg_if.det                 cfg,
    input  dsp_pkg::est_word_t     errors_i,
    input  dsp_pkg::bit_word_t     bits_cur_i,
    input  dsp_pkg::bit_word_t     bits_prev_i,
    output dsp_pkg::err_pos_word_t err_pos_o
);
    import dsp_pkg::*;

    est_word_t          errors_prev;
    est_t               estream [2*lanes];
    logic [2*lanes-1:0] bstream;
    err_pos_word_t      err_pos_d;

    assign bstream = {bits_cur_i, bits_prev_i};

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            estream[i]         = errors_prev[i];
            estream[lanes + i] = errors_i[i];
        end
    end

    always_comb begin
        logic signed [coef_w:0]       h0;
        logic signed [coef_w:0]       h1;
        logic signed [det_diff_w-1:0] hx0;
        logic signed [det_diff_w-1:0] hx1;
        logic signed [det_diff_w-1:0] e;
        logic signed [det_diff_w-1:0] p;
        logic signed [det_diff_w-1:0] d_cur;
        logic signed [det_diff_w-1:0] d_pe;
        logic signed [det_diff_w-1:0] d_pp;
        logic [cost_w-1:0]            c0;
        logic [cost_w-1:0]            c1;
        logic [cost_w-1:0]            c2;
        // Flipping a symbol moves the estimate by twice the tap
        h0 = $signed({cfg.chan_taps_val[0], 1'b0}) >>> cfg.chan_shift;
        h1 = $signed({cfg.chan_taps_val[1], 1'b0}) >>> cfg.chan_shift;
        hx0 = h0;
        hx1 = h1;
        for (int n = 0; n < lanes; n++) begin
            e = estream[lanes + n];
            p = estream[lanes + n - 1];
            d_cur = e - (bstream[lanes + n] ? hx0 : -hx0);
            d_pe  = e - (bstream[lanes + n - 1] ? hx1 : -hx1);
            d_pp  = p - (bstream[lanes + n - 1] ? hx0 : -hx0);
            c0 = e * e + p * p;
            c1 = d_cur * d_cur + p * p;
            c2 = d_pe * d_pe + d_pp * d_pp;
            // Ties keep the lower index
            if (c1 < c0 && c1 <= c2) begin
                err_pos_d[n] = pos_cur;
            end else if (c2 < c0 && c2 < c1) begin
                err_pos_d[n] = pos_prev;
            end else begin
                err_pos_d[n] = pos_none;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            errors_prev <= '0;
            err_pos_o   <= '0;
        end else begin
            errors_prev <= errors_i;
            err_pos_o   <= err_pos_d;
        end
    end

    for (genvar g = 0; g < lanes; g++) begin : g_pos_chk
        a_pos_valid: assert property (
            @(posedge clk_i) disable iff (!arst_n_i)
            err_pos_o[g] != 2'd3
        ) else $error("Lane %0d reported unused position code", g);
    end

endmodule

// File: design/word_delay.sv
`timescale 1ns/10ps

module word_delay #(
    parameter type word_t = logic,
    parameter int  depth  = 2
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  word_t word_i,
    output word_t taps_o [depth]
);

    // Tap 0 holds the newest word
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < depth; i++) begin
                taps_o[i] <= '0;
            end
        end else begin
            taps_o[0] <= word_i;
            for (int i = 1; i < depth; i++) begin
                taps_o[i] <= taps_o[i-1];
            end
        end
    end

    a_depth_min: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        depth >= 1
    ) else $error("word_delay needs depth of at least 1");

endmodule

// File: filelist.f
design/dsp_pkg.sv
design/dsp_cfg_if.sv
design/word_delay.sv
design/ffe_slicer.sv
design/channel_error.sv
design/sliding_detector.sv
design/datapath_core.sv
verification/tb_clock_gen.sv
verification/tb_datapath_core.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_datapath_core &&
{ ./obj_dir/Vtb_datapath_core > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "Simulation finished: PASS" sim.log &&
echo "Run passed" ||
{ echo "Run failed"; exit 1; }

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2) clk_o = ~clk_o;
        end
    end

    // Released just after the last reset edge
    initial begin
        arst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

// File: verification/tb_datapath_core.sv
`timescale 1ns/10ps

module tb_datapath_core;
    import dsp_pkg::*;

    localparam int id_words    = 200;
    localparam int eq_words    = 300;
    localparam int chan_words  = 150;
    localparam int det_words   = 300;
    localparam int dir_words   = 40;
    localparam int drain       = 4;
    localparam int test_cycles = 3 + id_words + eq_words + chan_words + det_words
                                 + dir_words + drain;
    // Rounded up, a couple hundred cycles of margin
    localparam int timeout_cycles = (test_cycles / 100 + 3) * 100;
    localparam int ofs        = 4;
    localparam int hist_len   = timeout_cycles + 2 * ofs;
    localparam int flip_gap   = 12;
    localparam int flip_first = 6;

    logic          clk;
    logic          arst_n;
    code_word_t    adc_codes;
    ffe_coef_t     ffe_weights;
    shift_t        ffe_shift;
    est_t          slice_thresh;
    chan_coef_t    chan_coefs;
    shift_t        chan_shift;
    bit_word_t     bits;
    est_word_t     errors;
    err_pos_word_t err_pos;

    // Word i lives at index i + ofs, config of edge j at j + ofs
    code_word_t    code_hist [hist_len];
    bit_word_t     bit_ref   [hist_len];
    est_word_t     err_ref   [hist_len];
    err_pos_word_t pos_ref   [hist_len];
    ffe_coef_t     w_hist    [hist_len];
    shift_t        fsh_hist  [hist_len];
    est_t          thr_hist  [hist_len];
    chan_coef_t    ct_hist   [hist_len];
    shift_t        csh_hist  [hist_len];

    int n_edges    = 0;
    int dir_first  = -1;
    int n_pos_cur  = 0;
    int n_pos_prev = 0;
    int cycles     = 0;

    tb_clock_gen #(
        .period_ns    (8),
        .reset_cycles (3)
    ) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    datapath_core i_dut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .adc_codes_i    (adc_codes),
        .ffe_weights_i  (ffe_weights),
        .ffe_shift_i    (ffe_shift),
        .slice_thresh_i (slice_thresh),
        .chan_taps_i    (chan_coefs),
        .chan_shift_i   (chan_shift),
        .bits_o         (bits),
        .errors_o       (errors),
        .err_pos_o      (err_pos)
    );

    function automatic int clamp_est(input int x);
        if (x > (1 << (est_w - 1)) - 1) begin
            return (1 << (est_w - 1)) - 1;
        end else if (x < -(1 << (est_w - 1))) begin
            return -(1 << (est_w - 1));
        end
        return x;
    endfunction

    // Bits of word i, sliced with the settings seen at edge i+1
    function automatic bit_word_t slice_word(input int i);
        bit_word_t b;
        int acc;
        int x;
        int eq;
        for (int n = 0; n < lanes; n++) begin
            acc = 0;
            for (int k = 0; k < ffe_taps; k++) begin
                if (n - k >= 0) begin
                    x = $signed(code_hist[i + ofs][n - k]);
                end else begin
                    x = $signed(code_hist[i - 1 + ofs][n - k + lanes]);
                end
                acc = acc + int'($signed(w_hist[i + 1 + ofs][k])) * x;
            end
            eq = clamp_est(acc >>> fsh_hist[i + 1 + ofs]);
            b[n] = (eq >= int'($signed(thr_hist[i + 1 + ofs])));
        end
        return b;
    endfunction

    // Channel estimate minus code, settings of edge i+2
    function automatic est_word_t channel_errors(input int i);
        est_word_t e;
        int acc;
        int est;
        logic bt;
        for (int n = 0; n < lanes; n++) begin
            acc = 0;
            for (int k = 0; k < chan_taps; k++) begin
                if (n - k >= 0) begin
                    bt = bit_ref[i + ofs][n - k];
                end else begin
                    bt = bit_ref[i - 1 + ofs][n - k + lanes];
                end
                acc = acc + (bt ? 1 : -1) * int'($signed(ct_hist[i + 2 + ofs][k]));
            end
            est = clamp_est(acc >>> csh_hist[i + 2 + ofs]);
            e[n] = est_t'(clamp_est(est - int'($signed(code_hist[i + ofs][n]))));
        end
        return e;
    endfunction

    // Smallest squared cost over no flip, current flip, previous flip
    function automatic err_pos_word_t detect_flips(input int i);
        err_pos_word_t r;
        int h0, h1, e, p, sc, sp;
        int d0, d1, d2;
        int c0, c1, c2, best;
        h0 = (2 * int'($signed(ct_hist[i + 3 + ofs][0]))) >>> csh_hist[i + 3 + ofs];
        h1 = (2 * int'($signed(ct_hist[i + 3 + ofs][1]))) >>> csh_hist[i + 3 + ofs];
        for (int n = 0; n < lanes; n++) begin
            e  = $signed(err_ref[i + ofs][n]);
            sc = bit_ref[i + ofs][n] ? 1 : -1;
            if (n > 0) begin
                p  = $signed(err_ref[i + ofs][n - 1]);
                sp = bit_ref[i + ofs][n - 1] ? 1 : -1;
            end else begin
                p  = $signed(err_ref[i - 1 + ofs][lanes - 1]);
                sp = bit_ref[i - 1 + ofs][lanes - 1] ? 1 : -1;
            end
            d0 = e - sc * h0;
            d1 = e - sp * h1;
            d2 = p - sp * h0;
            c0 = e * e + p * p;
            c1 = d0 * d0 + p * p;
            c2 = d1 * d1 + d2 * d2;
            r[n] = 2'd0;
            best = c0;
            if (c1 < best) begin
                r[n] = 2'd1;
                best = c1;
            end
            if (c2 < best) begin
                r[n] = 2'd2;
            end
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Output mismatch at edge %0d", n_edges - 1);
        end
    endtask

    task automatic send_word(input code_word_t w);
        adc_codes = w;
        @(posedge clk);
        #1;
    endtask

    function automatic code_word_t random_word();
        code_word_t w;
        for (int l = 0; l < lanes; l++) begin
            w[l] = code_t'($urandom);
            // Some lanes at full scale
            if ($urandom % 8 == 0) begin
                w[l] = ($urandom % 2) ? code_t'(127) : code_t'(-128);
            end
        end
        return w;
    endfunction

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_word(random_word());
        end
    endtask

    task automatic pick_ffe_config(input int max_shift);
        for (int k = 0; k < ffe_taps; k++) begin
            ffe_weights[k] = coef_t'($urandom);
        end
        ffe_shift    = shift_t'($urandom % (max_shift + 1));
        slice_thresh = est_t'(int'($urandom % 512) - 256);
    endtask

    task automatic pick_chan_config();
        for (int k = 0; k < chan_taps; k++) begin
            chan_coefs[k] = coef_t'($urandom);
        end
        chan_shift = shift_t'($urandom % 8);
    endtask

    // Snapshot of inputs at every active edge
    always @(posedge clk) begin
        if (arst_n) begin
            code_hist[n_edges + ofs] = adc_codes;
            w_hist[n_edges + ofs]    = ffe_weights;
            fsh_hist[n_edges + ofs]  = ffe_shift;
            thr_hist[n_edges + ofs]  = slice_thresh;
            ct_hist[n_edges + ofs]   = chan_coefs;
            csh_hist[n_edges + ofs]  = chan_shift;
            n_edges = n_edges + 1;
        end
    end

    initial begin : compare_outputs
        int j;
        @(posedge clk);
        forever begin
            @(negedge clk);
            j = n_edges - 1;
            if (!arst_n || n_edges == 0) begin
                check_value("bits_o", '0, bits);
                check_value("errors_o", '0, errors);
                check_value("err_pos_o", '0, err_pos);
            end else begin
                bit_ref[j - 1 + ofs] = slice_word(j - 1);
                err_ref[j - 2 + ofs] = channel_errors(j - 2);
                pos_ref[j - 3 + ofs] = detect_flips(j - 3);
                check_value("bits_o", bit_ref[j - 1 + ofs], bits);
                check_value("errors_o", err_ref[j - 2 + ofs], errors);
                check_value("err_pos_o", pos_ref[j - 3 + ofs], err_pos);
                if (dir_first >= 0 && j - 3 >= dir_first) begin
                    for (int l = 0; l < lanes; l++) begin
                        n_pos_cur  += (pos_ref[j - 3 + ofs][l] == 2'd1);
                        n_pos_prev += (pos_ref[j - 3 + ofs][l] == 2'd2);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "Timeout");
    end

    initial begin : main
        int sym [dir_words * lanes];
        int s;
        int y;
        code_word_t w;
        void'($urandom(32'hc018));
        for (int i = 0; i < hist_len; i++) begin
            code_hist[i] = '0;
            bit_ref[i]   = '0;
            err_ref[i]   = '0;
            pos_ref[i]   = '0;
        end
        adc_codes      = '0;
        ffe_weights    = '0;
        ffe_weights[0] = 8'sd1;
        ffe_shift      = '0;
        slice_thresh   = '0;
        pick_chan_config();
        @(posedge arst_n);

        // Identity equalizer, bits follow the code sign
        send_random(id_words);

        // First set with no shift so the clamp is hit
        for (int c = 0; c < 3; c++) begin
            pick_ffe_config(c == 0 ? 0 : ffe_shift_max);
            send_random(eq_words / 3);
        end
        for (int c = 0; c < 3; c++) begin
            pick_chan_config();
            send_random(chan_words / 3);
        end
        for (int c = 0; c < 3; c++) begin
            pick_ffe_config(6);
            pick_chan_config();
            send_random(det_words / 3);
        end

        // Codes from the channel model, one flipped sample per group
        ffe_weights    = '0;
        ffe_weights[0] = 8'sd1;
        ffe_shift      = '0;
        slice_thresh   = '0;
        chan_coefs[0]  = 8'sd64;
        chan_coefs[1]  = 8'sd32;
        chan_coefs[2]  = 8'sd16;
        chan_shift     = '0;
        for (int i = 0; i < dir_words * lanes; i++) begin
            sym[i] = ($urandom % 2) ? 1 : -1;
        end
        for (int i = flip_first; i < dir_words * lanes; i += flip_gap) begin
            sym[i - 2] = -1;
            sym[i - 1] = -1;
            sym[i]     = 1;
        end
        for (int i = 0; i < dir_words; i++) begin
            for (int l = 0; l < lanes; l++) begin
                s = i * lanes + l;
                y = 64 * sym[s] + 32 * (s >= 1 ? sym[s - 1] : -1)
                    + 16 * (s >= 2 ? sym[s - 2] : -1);
                if (s % flip_gap == flip_first) begin
                    y = -y;
                end
                w[l] = code_t'(y);
            end
            if (i == 0) begin
                dir_first = n_edges;
            end
            send_word(w);
        end
        for (int i = 0; i < drain; i++) begin
            send_word('0);
        end

        if (n_pos_cur > 0 && n_pos_prev > 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Directed detector sequence did not report both flip positions");
            $display("Simulation finished: FAIL");
            $fatal(1, "Missing detector results");
        end
    end

endmodule
